// File: Bender.yml
package:
  name: idu

sources:
  # Package first, then the RTL blocks, top level last
  - files:
      - src/idu_pkg.sv
      - src/dispatch_decode.sv
      - src/rs_class_pool.sv
      - src/dispatch_issue.sv
      - src/reg_status_table.sv
      - src/idu.sv

  - target: simulation
    files:
      - dv/idu_tb.sv

// File: dv/idu_tb.sv
/* Dispatch unit testbench
   Random instruction pairs and done pulses checked against a station and register model */
`timescale 1ns/1ps

module idu_tb;

   localparam int RS_PER_CLASS = 2;
   localparam int NUM_REG      = 4;
   localparam int NUM_RS       = idu_pkg::NUM_CLASS * RS_PER_CLASS;
   localparam int NUM_CYCLES   = 2000;                       // Instruction pairs offered
   localparam int MAX_CYCLES   = NUM_CYCLES + NUM_CYCLES / 4;

   logic                                              clk;
   logic                                              rst_n;
   idu_pkg::inst_t                                    inst_1;
   idu_pkg::inst_t                                    inst_2;
   logic                                              take_1;
   logic                                              take_2;
   logic [idu_pkg::NUM_CLASS-1:0][RS_PER_CLASS-1:0]   done;
   idu_pkg::dispatch_bus_t                            bus_1;
   idu_pkg::dispatch_bus_t                            bus_2;
   idu_pkg::reg_stat_t [NUM_REG-1:0]                  reg_status;

   integer                 seed;
   int                     cycle_count;
   idu_pkg::inst_t         cur_1;        // Slot contents held by the upstream
   idu_pkg::inst_t         cur_2;
   logic                   new_1;        // Slot needs a fresh instruction
   logic                   new_2;
   logic [NUM_RS-1:0]      cur_done;     // Bit t-1 is the done of tag t
   logic [NUM_RS-1:0]      m_busy;
   idu_pkg::reg_stat_t     m_reg [NUM_REG];
   idu_pkg::dispatch_bus_t exp_bus_1;
   idu_pkg::dispatch_bus_t exp_bus_2;

   idu #(
      .RS_PER_CLASS (RS_PER_CLASS),
      .NUM_REG      (NUM_REG)
   ) dut0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .inst_1     (inst_1),
      .inst_2     (inst_2),
      .take_1     (take_1),
      .take_2     (take_2),
      .done       (done),
      .bus_1      (bus_1),
      .bus_2      (bus_2),
      .reg_status (reg_status)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   task automatic stop_with_failure(input string line);
      $display("%s", line);
      $display("Checks failed");
      $fatal(1, "Stopping at first error");
   endtask

   function automatic int draw(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic in_reg_range(input idu_pkg::field_t f);
      return (int'(f) >= idu_pkg::REG_BASE) && (int'(f) < idu_pkg::REG_BASE + NUM_REG);
   endfunction

   // Lowest free station of a class, skipping one already offered
   function automatic int lowest_free(input int cls, input int skip);
      for (int i = 0; i < RS_PER_CLASS; i++) begin
         if (!m_busy[cls * RS_PER_CLASS + i] && (i != skip)) return i;
      end
      return -1;
   endfunction

   function automatic idu_pkg::dispatch_bus_t expected_bus(input idu_pkg::inst_t x,
                                                           input int cls, input int st);
      idu_pkg::dispatch_bus_t b;
      b.valid        = 1'b1;
      b.rs_tag       = idu_pkg::rs_tag_t'(cls * RS_PER_CLASS + st + 1);
      b.src0         = x.src0;
      b.src1         = x.src1;
      b.src0_not_reg = !in_reg_range(x.src0);
      b.src1_not_reg = !in_reg_range(x.src1);
      return b;
   endfunction

   function automatic string bus_text(input idu_pkg::dispatch_bus_t b);
      return $sformatf("v=%b tag=%0d src0=%0d src1=%0d nr=%b%b", b.valid, b.rs_tag,
                       b.src0, b.src1, b.src0_not_reg, b.src1_not_reg);
   endfunction

   task automatic random_inst(output idu_pkg::inst_t x);
      x.valid = (draw(5) != 0);                  // Mostly valid
      x.op    = idu_pkg::field_t'(draw(7));      // 0, 5 and 6 are illegal
      x.dest  = idu_pkg::field_t'(7 + draw(7));
      x.src0  = idu_pkg::field_t'(7 + draw(7));
      x.src1  = idu_pkg::field_t'(7 + draw(7));
   endtask

   ////////////////////////////////////////
   // Checks and model
   ////////////////////////////////////////

   task automatic check_registered();
      assert (bus_1 === exp_bus_1) else stop_with_failure($sformatf(
         "MISMATCH at %0t ns: bus_1 %s, expected %s", $time, bus_text(bus_1),
         bus_text(exp_bus_1)));
      assert (bus_2 === exp_bus_2) else stop_with_failure($sformatf(
         "MISMATCH at %0t ns: bus_2 %s, expected %s", $time, bus_text(bus_2),
         bus_text(exp_bus_2)));
      for (int i = 0; i < NUM_REG; i++) begin
         assert (reg_status[i] === m_reg[i]) else stop_with_failure($sformatf(
            "MISMATCH at %0t ns: reg %0d busy=%b tag=%0d, expected busy=%b tag=%0d",
            $time, i + idu_pkg::REG_BASE, reg_status[i].busy, reg_status[i].tag,
            m_reg[i].busy, m_reg[i].tag));
      end
   endtask

   task automatic drive_stimulus();
      if (new_1) random_inst(cur_1);
      if (new_2) random_inst(cur_2);
      cur_done = m_busy & NUM_RS'($random(seed)) & NUM_RS'($random(seed));  // Busy only
      inst_1   = cur_1;
      inst_2   = cur_2;
      done     = cur_done;
   endtask

   task automatic predict_and_check();
      int                 cls_1;
      int                 cls_2;
      int                 st_1;
      int                 st_2;
      int                 idx;
      logic               legal_1;
      logic               legal_2;
      logic               hazard_2;
      logic               disp_1;
      logic               disp_2;
      logic               exp_take_1;
      logic               exp_take_2;
      idu_pkg::reg_stat_t next_reg [NUM_REG];
      legal_1  = cur_1.valid && (cur_1.op >= 4'd1) && (cur_1.op <= 4'd4);
      legal_2  = cur_2.valid && (cur_2.op >= 4'd1) && (cur_2.op <= 4'd4);
      cls_1    = int'(cur_1.op) - 1;
      cls_2    = int'(cur_2.op) - 1;
      hazard_2 = legal_1 && ((cur_2.src0 == cur_1.dest) || (cur_2.src1 == cur_1.dest));
      st_1     = legal_1 ? lowest_free(cls_1, -1) : -1;
      disp_1   = legal_1 && (st_1 >= 0);
      st_2     = -1;
      if (disp_1 && legal_2 && !hazard_2) begin
         st_2 = lowest_free(cls_2, (cls_2 == cls_1) ? st_1 : -1);
      end
      disp_2     = (st_2 >= 0);
      exp_take_1 = cur_1.valid && (disp_1 || !legal_1);
      exp_take_2 = exp_take_1 && cur_2.valid && (disp_2 || !legal_2);

      assert (!(take_2 && !take_1)) else stop_with_failure($sformatf(
         "MISMATCH at %0t ns: take_2 high while take_1 low", $time));
      assert ((take_1 === exp_take_1) && (take_2 === exp_take_2)) else stop_with_failure(
         $sformatf("MISMATCH at %0t ns: take_1=%b take_2=%b, expected %b %b",
                   $time, take_1, take_2, exp_take_1, exp_take_2));

      // Clears first, new writes override them, slot 2 last
      for (int i = 0; i < NUM_REG; i++) begin
         next_reg[i] = m_reg[i];
         if (m_reg[i].busy && cur_done[int'(m_reg[i].tag) - 1]) next_reg[i] = '0;
      end
      if (disp_1 && in_reg_range(cur_1.dest)) begin
         idx                = int'(cur_1.dest) - idu_pkg::REG_BASE;
         next_reg[idx].busy = 1'b1;
         next_reg[idx].tag  = idu_pkg::rs_tag_t'(cls_1 * RS_PER_CLASS + st_1 + 1);
      end
      if (disp_2 && in_reg_range(cur_2.dest)) begin
         idx                = int'(cur_2.dest) - idu_pkg::REG_BASE;
         next_reg[idx].busy = 1'b1;
         next_reg[idx].tag  = idu_pkg::rs_tag_t'(cls_2 * RS_PER_CLASS + st_2 + 1);
      end
      m_reg  = next_reg;
      m_busy = m_busy & ~cur_done;
      if (disp_1) m_busy[cls_1 * RS_PER_CLASS + st_1] = 1'b1;
      if (disp_2) m_busy[cls_2 * RS_PER_CLASS + st_2] = 1'b1;
      exp_bus_1 = disp_1 ? expected_bus(cur_1, cls_1, st_1) : '0;
      exp_bus_2 = disp_2 ? expected_bus(cur_2, cls_2, st_2) : '0;
      new_1     = exp_take_1 || !cur_1.valid;   // Idle slots may change freely
      new_2     = exp_take_2 || !cur_2.valid;
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      seed      = 32'h2430_a9fa;
      rst_n     = 1'b0;
      inst_1    = '0;
      inst_2    = '0;
      done      = '0;
      cur_1     = '0;
      cur_2     = '0;
      cur_done  = '0;
      new_1     = 1'b1;
      new_2     = 1'b1;
      m_busy    = '0;
      exp_bus_1 = '0;
      exp_bus_2 = '0;
      for (int i = 0; i < NUM_REG; i++) m_reg[i] = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      #1;
      check_registered();                        // Everything idle after reset
      assert (!take_1 && !take_2) else stop_with_failure($sformatf(
         "MISMATCH at %0t ns: take high after reset with no slot valid", $time));
      for (int c = 0; c < NUM_CYCLES; c++) begin
         @(negedge clk);
         check_registered();
         drive_stimulus();
         #1;
         predict_and_check();
      end
      @(negedge clk);
      check_registered();
      $display("All checks passed");
      $finish;
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < MAX_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $fatal(1, "Run stopped on timeout");
   end

endmodule

// File: idu.f
src/idu_pkg.sv
src/dispatch_decode.sv
src/rs_class_pool.sv
src/dispatch_issue.sv
src/reg_status_table.sv
src/idu.sv
dv/idu_tb.sv

// File: src/dispatch_decode.sv
/* Dispatch decoder
   Classifies both offered slots, checks the pair hazard and raises class requests */
`timescale 1ns/1ps

module dispatch_decode #(
   parameter int NUM_REG = 4
) (
   input  idu_pkg::inst_t                     inst_1,
   input  idu_pkg::inst_t                     inst_2,
   output idu_pkg::slot_req_t                 slot_1,
   output idu_pkg::slot_req_t                 slot_2,
   output logic [idu_pkg::NUM_CLASS-1:0]      req_1,
   output logic [idu_pkg::NUM_CLASS-1:0]      req_2
);

   // True for a field inside the architectural register range
   function automatic logic is_reg(idu_pkg::field_t f);
      return (int'(f) >= idu_pkg::REG_BASE) && (int'(f) < idu_pkg::REG_BASE + NUM_REG);
   endfunction

   function automatic idu_pkg::slot_req_t decode_slot(idu_pkg::inst_t inst);
      idu_pkg::slot_req_t s;
      s              = '0;
      s.valid        = inst.valid;
      s.dest         = inst.dest;
      s.src0         = inst.src0;
      s.src1         = inst.src1;
      s.src0_not_reg = !is_reg(inst.src0);
      s.src1_not_reg = !is_reg(inst.src1);
      case (inst.op)
         4'd1:    s.cls = idu_pkg::CLS_ADD;
         4'd2:    s.cls = idu_pkg::CLS_MULT;
         4'd3:    s.cls = idu_pkg::CLS_FETCH;
         4'd4:    s.cls = idu_pkg::CLS_STORE;
         default: s.cls = idu_pkg::CLS_ADD;   // Don't care, slot is illegal
      endcase
      s.legal  = inst.valid && (inst.op >= 4'd1) && (inst.op <= 4'd4);
      s.hazard = 1'b0;
      return s;
   endfunction

   idu_pkg::slot_req_t dec_1;
   idu_pkg::slot_req_t dec_2;

   always_comb begin
      dec_1 = decode_slot(inst_1);
      dec_2 = decode_slot(inst_2);
      // RAW inside the pair, slot 2 must wait a cycle
      dec_2.hazard = dec_1.legal &&
                     ((inst_2.src0 == inst_1.dest) || (inst_2.src1 == inst_1.dest));
   end

   assign slot_1 = dec_1;
   assign slot_2 = dec_2;

   ////////////////////////////////////////
   // Per-class requests
   ////////////////////////////////////////

   always_comb begin
      for (int k = 0; k < idu_pkg::NUM_CLASS; k++) begin
         req_1[k] = dec_1.legal && (int'(dec_1.cls) == k);
         req_2[k] = dec_2.legal && !dec_2.hazard && (int'(dec_2.cls) == k);
      end
   end

endmodule

// File: src/dispatch_issue.sv
/* Dispatch issue stage
   In-order grant of both slots, consume pulses, registered buses and table writes */
`timescale 1ns/1ps

module dispatch_issue #(
   parameter int NUM_REG = 4
) (
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  idu_pkg::slot_req_t                        slot_1,
   input  idu_pkg::slot_req_t                        slot_2,
   input  logic [idu_pkg::NUM_CLASS-1:0]             ok_1,
   input  logic [idu_pkg::NUM_CLASS-1:0]             ok_2,
   input  idu_pkg::rs_tag_t [idu_pkg::NUM_CLASS-1:0] tag_1,
   input  idu_pkg::rs_tag_t [idu_pkg::NUM_CLASS-1:0] tag_2,
   output logic [idu_pkg::NUM_CLASS-1:0]             commit_1,
   output logic [idu_pkg::NUM_CLASS-1:0]             commit_2,
   output logic                                      take_1,
   output logic                                      take_2,
   output idu_pkg::dispatch_bus_t                    bus_1,
   output idu_pkg::dispatch_bus_t                    bus_2,
   output logic                                      wr_en_1,
   output logic [$clog2(NUM_REG)-1:0]                wr_idx_1,
   output idu_pkg::rs_tag_t                          wr_tag_1,
   output logic                                      wr_en_2,
   output logic [$clog2(NUM_REG)-1:0]                wr_idx_2,
   output idu_pkg::rs_tag_t                          wr_tag_2
);

   localparam int IDX_W = $clog2(NUM_REG);

   function automatic idu_pkg::dispatch_bus_t make_bus(idu_pkg::slot_req_t s,
                                                       idu_pkg::rs_tag_t   t);
      idu_pkg::dispatch_bus_t b;
      b.valid        = 1'b1;
      b.rs_tag       = t;
      b.src0         = s.src0;
      b.src1         = s.src1;
      b.src0_not_reg = s.src0_not_reg;
      b.src1_not_reg = s.src1_not_reg;
      return b;
   endfunction

   function automatic logic dest_in_range(idu_pkg::field_t d);
      return (int'(d) >= idu_pkg::REG_BASE) && (int'(d) < idu_pkg::REG_BASE + NUM_REG);
   endfunction

   logic             disp_1;
   logic             disp_2;
   idu_pkg::rs_tag_t gnt_tag_1;
   idu_pkg::rs_tag_t gnt_tag_2;

   ////////////////////////////////////////
   // Grant and consume
   ////////////////////////////////////////

   assign disp_1    = slot_1.legal && ok_1[slot_1.cls];
   assign disp_2    = disp_1 && slot_2.legal && !slot_2.hazard && ok_2[slot_2.cls];
   assign gnt_tag_1 = tag_1[slot_1.cls];
   assign gnt_tag_2 = tag_2[slot_2.cls];

   assign commit_1 = disp_1 ? (idu_pkg::NUM_CLASS'(1) << slot_1.cls) : '0;
   assign commit_2 = disp_2 ? (idu_pkg::NUM_CLASS'(1) << slot_2.cls) : '0;

   // Illegal ops are swallowed, slot 2 never passes slot 1
   assign take_1 = slot_1.valid && (disp_1 || !slot_1.legal);
   assign take_2 = take_1 && slot_2.valid && (disp_2 || !slot_2.legal);

   // Register table write ports, only for dests that name a register
   assign wr_en_1  = disp_1 && dest_in_range(slot_1.dest);
   assign wr_idx_1 = IDX_W'(slot_1.dest - idu_pkg::field_t'(idu_pkg::REG_BASE));
   assign wr_tag_1 = gnt_tag_1;
   assign wr_en_2  = disp_2 && dest_in_range(slot_2.dest);
   assign wr_idx_2 = IDX_W'(slot_2.dest - idu_pkg::field_t'(idu_pkg::REG_BASE));
   assign wr_tag_2 = gnt_tag_2;

   ////////////////////////////////////////
   // Dispatch buses
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         bus_1 <= '0;
         bus_2 <= '0;
      end else begin
         bus_1 <= disp_1 ? make_bus(slot_1, gnt_tag_1) : '0;
         bus_2 <= disp_2 ? make_bus(slot_2, gnt_tag_2) : '0;
      end
   end

endmodule

// File: src/idu.sv
/* Two-wide instruction dispatch unit
   Decode, per-class station pools, issue and register status table */
`timescale 1ns/1ps

module idu #(
   parameter int RS_PER_CLASS = 2,   // Up to 3 fits the tag
   parameter int NUM_REG      = 4
) (
   input  logic                                              clk,
   input  logic                                              rst_n,
   input  idu_pkg::inst_t                                    inst_1,
   input  idu_pkg::inst_t                                    inst_2,
   output logic                                              take_1,
   output logic                                              take_2,
   input  logic [idu_pkg::NUM_CLASS-1:0][RS_PER_CLASS-1:0]   done,
   output idu_pkg::dispatch_bus_t                            bus_1,
   output idu_pkg::dispatch_bus_t                            bus_2,
   output idu_pkg::reg_stat_t [NUM_REG-1:0]                  reg_status
);

   idu_pkg::slot_req_t                        slot_1;
   idu_pkg::slot_req_t                        slot_2;
   logic [idu_pkg::NUM_CLASS-1:0]             req_1;
   logic [idu_pkg::NUM_CLASS-1:0]             req_2;
   logic [idu_pkg::NUM_CLASS-1:0]             ok_1;
   logic [idu_pkg::NUM_CLASS-1:0]             ok_2;
   idu_pkg::rs_tag_t [idu_pkg::NUM_CLASS-1:0] tag_1;
   idu_pkg::rs_tag_t [idu_pkg::NUM_CLASS-1:0] tag_2;
   logic [idu_pkg::NUM_CLASS-1:0]             commit_1;
   logic [idu_pkg::NUM_CLASS-1:0]             commit_2;
   logic                                      wr_en_1;
   logic                                      wr_en_2;
   logic [$clog2(NUM_REG)-1:0]                wr_idx_1;
   logic [$clog2(NUM_REG)-1:0]                wr_idx_2;
   idu_pkg::rs_tag_t                          wr_tag_1;
   idu_pkg::rs_tag_t                          wr_tag_2;

   dispatch_decode #(.NUM_REG(NUM_REG)) u_decode (
      .inst_1 (inst_1),
      .inst_2 (inst_2),
      .slot_1 (slot_1),
      .slot_2 (slot_2),
      .req_1  (req_1),
      .req_2  (req_2)
   );

   ////////////////////////////////////////
   // One station pool per class
   ////////////////////////////////////////

   for (genvar k = 0; k < idu_pkg::NUM_CLASS; k++) begin : g_pool
      rs_class_pool #(
         .RS_PER_CLASS (RS_PER_CLASS),
         .CLASS_ID     (k)
      ) u_pool (
         .clk      (clk),
         .rst_n    (rst_n),
         .req_1    (req_1[k]),
         .req_2    (req_2[k]),
         .commit_1 (commit_1[k]),
         .commit_2 (commit_2[k]),
         .done     (done[k]),
         .ok_1     (ok_1[k]),
         .ok_2     (ok_2[k]),
         .tag_1    (tag_1[k]),
         .tag_2    (tag_2[k])
      );
   end

   dispatch_issue #(.NUM_REG(NUM_REG)) u_issue (
      .clk      (clk),
      .rst_n    (rst_n),
      .slot_1   (slot_1),
      .slot_2   (slot_2),
      .ok_1     (ok_1),
      .ok_2     (ok_2),
      .tag_1    (tag_1),
      .tag_2    (tag_2),
      .commit_1 (commit_1),
      .commit_2 (commit_2),
      .take_1   (take_1),
      .take_2   (take_2),
      .bus_1    (bus_1),
      .bus_2    (bus_2),
      .wr_en_1  (wr_en_1),
      .wr_idx_1 (wr_idx_1),
      .wr_tag_1 (wr_tag_1),
      .wr_en_2  (wr_en_2),
      .wr_idx_2 (wr_idx_2),
      .wr_tag_2 (wr_tag_2)
   );

   reg_status_table #(
      .NUM_REG      (NUM_REG),
      .RS_PER_CLASS (RS_PER_CLASS)
   ) u_reg_table (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_en_1    (wr_en_1),
      .wr_idx_1   (wr_idx_1),
      .wr_tag_1   (wr_tag_1),
      .wr_en_2    (wr_en_2),
      .wr_idx_2   (wr_idx_2),
      .wr_tag_2   (wr_tag_2),
      .done       (done),
      .reg_status (reg_status)
   );

endmodule

// File: src/idu_pkg.sv
/* Instruction dispatch unit shared definitions
   Field widths, station tags, class encoding and the structs passed between blocks */
package idu_pkg;

   ////////////////////////////////////////
   // Widths and constants
   ////////////////////////////////////////

   typedef logic [3:0] field_t;   // Op, register or source field
   typedef logic [3:0] rs_tag_t;  // Station tag, 0 means none

   localparam int NUM_CLASS = 4;  // ADD, MULT, FETCH, STORE
   localparam int REG_BASE  = 9;  // Number of first architectural register

   // Tag = class index * stations per class + station index + 1
   typedef enum logic [1:0] {
      CLS_ADD,
      CLS_MULT,
      CLS_FETCH,
      CLS_STORE
   } op_class_e;

   ////////////////////////////////////////
   // Structs
   ////////////////////////////////////////

   typedef struct packed {
      logic   valid;
      field_t op;
      field_t dest;
      field_t src0;
      field_t src1;
   } inst_t;

   typedef struct packed {
      logic      valid;         // Slot offered this cycle
      logic      legal;         // Valid with op 1 to 4
      op_class_e cls;
      field_t    dest;
      field_t    src0;
      field_t    src1;
      logic      src0_not_reg;
      logic      src1_not_reg;
      logic      hazard;        // Reads the dest of slot 1
   } slot_req_t;

   typedef struct packed {
      logic    valid;
      rs_tag_t rs_tag;
      field_t  src0;
      field_t  src1;
      logic    src0_not_reg;
      logic    src1_not_reg;
   } dispatch_bus_t;

   typedef struct packed {
      logic    busy;
      rs_tag_t tag;           // Station that will write the register
   } reg_stat_t;

endpackage

// File: src/reg_status_table.sv
/* Register status table
   Pending writer tag per architectural register, set on dispatch, cleared on done */
`timescale 1ns/1ps

module reg_status_table #(
   parameter int NUM_REG      = 4,
   parameter int RS_PER_CLASS = 2
) (
   input  logic                                              clk,
   input  logic                                              rst_n,
   input  logic                                              wr_en_1,
   input  logic [$clog2(NUM_REG)-1:0]                        wr_idx_1,
   input  idu_pkg::rs_tag_t                                  wr_tag_1,
   input  logic                                              wr_en_2,
   input  logic [$clog2(NUM_REG)-1:0]                        wr_idx_2,
   input  idu_pkg::rs_tag_t                                  wr_tag_2,
   input  logic [idu_pkg::NUM_CLASS-1:0][RS_PER_CLASS-1:0]   done,
   output idu_pkg::reg_stat_t [NUM_REG-1:0]                  reg_status
);

   localparam int NUM_RS = idu_pkg::NUM_CLASS * RS_PER_CLASS;

   // Bit t is the done pulse of the station with tag t, bit 0 is never set
   logic [NUM_RS:0] done_by_tag;

   assign done_by_tag = {done, 1'b0};

   ////////////////////////////////////////
   // Entry update
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         reg_status <= '0;
      end else begin
         for (int i = 0; i < NUM_REG; i++) begin
            if (wr_en_2 && (int'(wr_idx_2) == i)) begin        // Younger write wins
               reg_status[i].busy <= 1'b1;
               reg_status[i].tag  <= wr_tag_2;
            end else if (wr_en_1 && (int'(wr_idx_1) == i)) begin
               reg_status[i].busy <= 1'b1;
               reg_status[i].tag  <= wr_tag_1;
            end else if (reg_status[i].busy && done_by_tag[reg_status[i].tag]) begin
               reg_status[i] <= '0;                          // Writer finished
            end
         end
      end
   end

endmodule

// File: src/rs_class_pool.sv
/* Reservation station pool for one instruction class
   Busy bits plus lowest-free selection for both dispatch slots */
`timescale 1ns/1ps

module rs_class_pool #(
   parameter int RS_PER_CLASS = 2,
   parameter int CLASS_ID     = 0
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    req_1,
   input  logic                    req_2,
   input  logic                    commit_1,
   input  logic                    commit_2,
   input  logic [RS_PER_CLASS-1:0] done,
   output logic                    ok_1,
   output logic                    ok_2,
   output idu_pkg::rs_tag_t        tag_1,
   output idu_pkg::rs_tag_t        tag_2
);

   // One-hot station to its global tag
   function automatic idu_pkg::rs_tag_t tag_of(logic [RS_PER_CLASS-1:0] onehot);
      idu_pkg::rs_tag_t t;
      t = '0;
      for (int i = 0; i < RS_PER_CLASS; i++) begin
         if (onehot[i]) begin
            t = idu_pkg::rs_tag_t'(CLASS_ID * RS_PER_CLASS + i + 1);
         end
      end
      return t;
   endfunction

   logic [RS_PER_CLASS-1:0] busy_q;
   logic [RS_PER_CLASS-1:0] free_1;
   logic [RS_PER_CLASS-1:0] free_2;
   logic [RS_PER_CLASS-1:0] pick_1;   // One-hot offer to slot 1
   logic [RS_PER_CLASS-1:0] pick_2;   // One-hot offer to slot 2
   logic [RS_PER_CLASS-1:0] set_mask;

   ////////////////////////////////////////
   // Free station selection
   ////////////////////////////////////////

   always_comb begin
      free_1 = ~busy_q;
      pick_1 = free_1 & (~free_1 + 1'b1);                // Lowest set bit
      free_2 = free_1 & ~(req_1 ? pick_1 : '0);          // Skip slot 1's offer
      pick_2 = free_2 & (~free_2 + 1'b1);
   end

   assign ok_1  = req_1 && (|pick_1);
   assign ok_2  = req_2 && (|pick_2);
   assign tag_1 = ok_1 ? tag_of(pick_1) : '0;
   assign tag_2 = ok_2 ? tag_of(pick_2) : '0;

   ////////////////////////////////////////
   // Busy bits
   ////////////////////////////////////////

   assign set_mask = (commit_1 ? pick_1 : '0) | (commit_2 ? pick_2 : '0);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy_q <= '0;
      end else begin
         busy_q <= (busy_q & ~done) | set_mask;   // New grant wins over done
      end
   end

endmodule
